// ==== hdl/decodeStage.sv ====
// unsupported opcodes decode to no-op control; operand fields are loaded even into a bubble
`timescale 1ns/1ns
`include "rvPipe_params.svh"
`default_nettype none

module decodeStage import rvPipePkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               hold,
    input  logic               loadStall,
    input  logic               branchTaken,
    input  instrWord           ifInstr,
    input  logic [`XLEN-1:0]   ifPc,
    input  logic               wbEn,
    input  logic [`REG_AW-1:0] wbRd,
    input  logic [`XLEN-1:0]   wbData,
    idExIf.decode              idEx
);

    // {regWrite, memToReg, memRead, memWrite, branch, aluSrc, aluOp[1:0]}
    logic [7:0]       ctl;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rdata1;
    logic [`XLEN-1:0] rdata2;

    regFile regFile_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .wbEn   (wbEn),
        .wbRd   (wbRd),
        .wbData (wbData),
        .rs1    (ifInstr.rView.rs1),
        .rs2    (ifInstr.rView.rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    // ============================================================
    // control and immediate decode
    // ============================================================
    always_comb begin
        imm = {{(`XLEN-12){ifInstr.rView.funct7[6]}}, ifInstr.rView.funct7, ifInstr.rView.rs2};
        case (ifInstr.rView.opcode)
            `OP_RTYPE:  ctl = {6'b100000, `ALUOP_REG};
            `OP_ITYPE:  ctl = {6'b100001, `ALUOP_IMM};
            `OP_LOAD:   ctl = {6'b111001, `ALUOP_ADD};
            `OP_STORE: begin
                ctl = {6'b000101, `ALUOP_ADD};
                imm = {{(`XLEN-12){ifInstr.sView.immHi[6]}}, ifInstr.sView.immHi,
                       ifInstr.sView.immLo};
            end
            `OP_BRANCH: begin
                ctl = {6'b000010, `ALUOP_BRANCH};
                // B-type bits reshuffled from the S-type fields
                imm = {{(`XLEN-12){ifInstr.sView.immHi[6]}}, ifInstr.sView.immLo[0],
                       ifInstr.sView.immHi[5:0], ifInstr.sView.immLo[4:1], 1'b0};
            end
            default:    ctl = '0;
        endcase
    end

    // control bits, cleared on squash or load-use bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {idEx.regWrite, idEx.memToReg, idEx.memRead, idEx.memWrite,
             idEx.branch, idEx.aluSrc, idEx.aluOp} <= '0;
        end else if (!hold) begin
            {idEx.regWrite, idEx.memToReg, idEx.memRead, idEx.memWrite,
             idEx.branch, idEx.aluSrc, idEx.aluOp} <= (branchTaken || loadStall) ? '0 : ctl;
        end
    end

    // operand payload
    always_ff @(posedge clk) begin
        if (!hold) begin
            idEx.rs1      <= ifInstr.rView.rs1;
            idEx.rs2      <= ifInstr.rView.rs2;
            idEx.rd       <= ifInstr.rView.rd;
            idEx.funct3   <= ifInstr.rView.funct3;
            idEx.funct7b5 <= ifInstr.rView.funct7[5];
            idEx.imm      <= imm;
            idEx.pc       <= ifPc;
            idEx.rdata1   <= rdata1;
            idEx.rdata2   <= rdata2;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/executeStage.sv ====
// branches are beq/bne only and resolve here; the store word leaves in bus (big-endian) order
`timescale 1ns/1ns
`include "rvPipe_params.svh"
`default_nettype none

module executeStage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              hold,
    input  logic [1:0]        fwdA,
    input  logic [1:0]        fwdB,
    input  logic [`XLEN-1:0]  wbData,
    idExIf.execute            idEx,
    exMemIf.execute           exMem,
    output logic              branchTaken,
    output logic [`XLEN-1:0]  branchTarget
);

    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] aluB;
    logic [`XLEN-1:0] aluResult;
    logic [3:0]       aluCode;

    // ============================================================
    // operand forwarding
    // ============================================================
    // bit 1 selects the memory stage, bit 0 the writeback bus
    assign opA  = fwdA[1] ? exMem.aluOut : fwdA[0] ? wbData : idEx.rdata1;
    assign opB  = fwdB[1] ? exMem.aluOut : fwdB[0] ? wbData : idEx.rdata2;
    assign aluB = idEx.aluSrc ? idEx.imm : opB;

    // ALU control
    always_comb begin
        case (idEx.aluOp)
            `ALUOP_REG:    aluCode = {idEx.funct7b5, idEx.funct3};
            // funct7 bit only matters for srai
            `ALUOP_IMM:    aluCode = {idEx.funct7b5 && idEx.funct3 == 3'b101, idEx.funct3};
            `ALUOP_BRANCH: aluCode = `ALU_SUB;
            default:       aluCode = `ALU_ADD;
        endcase
    end

    always_comb begin
        case (aluCode)
            `ALU_SUB: aluResult = opA - aluB;
            `ALU_SLT: aluResult = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(aluB)};
            `ALU_XOR: aluResult = opA ^ aluB;
            `ALU_OR:  aluResult = opA | aluB;
            `ALU_AND: aluResult = opA & aluB;
            `ALU_SLL: aluResult = opA << aluB[4:0];
            `ALU_SRL: aluResult = opA >> aluB[4:0];
            `ALU_SRA: aluResult = $signed(opA) >>> aluB[4:0];
            default:  aluResult = opA + aluB;
        endcase
    end

    // beq on zero difference, bne when funct3[0] set
    assign branchTaken  = idEx.branch && ((aluResult == '0) ^ idEx.funct3[0]);
    assign branchTarget = idEx.pc + idEx.imm;

    // ============================================================
    // execute/memory register
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exMem.regWrite <= 1'b0;
            exMem.memToReg <= 1'b0;
            exMem.memRead  <= 1'b0;
            exMem.memWrite <= 1'b0;
        end else if (!hold) begin
            exMem.regWrite <= idEx.regWrite;
            exMem.memToReg <= idEx.memToReg;
            exMem.memRead  <= idEx.memRead;
            exMem.memWrite <= idEx.memWrite;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            exMem.aluOut    <= aluResult;
            exMem.storeData <= {<<8{opB}};
            exMem.rd        <= idEx.rd;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fetchStage.sv ====
// icache returns big-endian words combinationally on icacheAddr; a taken branch wins over loadStall
`timescale 1ns/1ns
`include "rvPipe_params.svh"
`default_nettype none

module fetchStage import rvPipePkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              hold,
    input  logic              loadStall,
    input  logic              branchTaken,
    input  logic [`XLEN-1:0]  branchTarget,
    input  logic [`XLEN-1:0]  icacheRdata,
    output logic [`XLEN-3:0]  icacheAddr,
    output instrWord          ifInstr,
    output logic [`XLEN-1:0]  ifPc
);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] fetched;

    // word address out, big-endian bus word swapped to native order
    assign icacheAddr = pc[`XLEN-1:2];
    assign fetched    = {<<8{icacheRdata}};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= '0;
            ifInstr <= `INSTR_NOP;
            ifPc    <= '0;
        end else if (!hold) begin
            if (branchTaken) begin
                // squash the word fetched behind the branch
                pc      <= branchTarget;
                ifInstr <= `INSTR_BUBBLE;
            end else if (!loadStall) begin
                pc      <= pc + `PC_STEP;
                ifInstr <= fetched;
                ifPc    <= pc;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/hazardUnit.sv ====
// purely combinational; rs2 of an I-type word is compared too, which may add a spare bubble
`timescale 1ns/1ns
`include "rvPipe_params.svh"
`default_nettype none

module hazardUnit import rvPipePkg::*; (
    input  logic               icacheStall,
    input  logic               dcacheStall,
    input  logic               wbEn,
    input  logic [`REG_AW-1:0] wbRd,
    idExIf.hazard              idEx,
    exMemIf.hazard             exMem,
    input  instrWord           ifInstr,
    output logic               hold,
    output logic               loadStall,
    output logic [1:0]         fwdA,
    output logic [1:0]         fwdB
);

    logic memLive;
    logic wbLive;

    // any memory stall freezes the whole pipe
    assign hold = icacheStall || dcacheStall;

    // load in execute feeding the word in decode
    assign loadStall = idEx.memRead && (idEx.rd != '0) &&
                       (idEx.rd == ifInstr.rView.rs1 || idEx.rd == ifInstr.rView.rs2);

    // producers that write a real register
    assign memLive = exMem.regWrite && (exMem.rd != '0);
    assign wbLive  = wbEn && (wbRd != '0);

    // memory stage wins over writeback
    assign fwdA = {memLive && exMem.rd == idEx.rs1, wbLive && wbRd == idEx.rs1};
    assign fwdB = {memLive && exMem.rd == idEx.rs2, wbLive && wbRd == idEx.rs2};

endmodule

`default_nettype wire

// ==== hdl/memWbStage.sv ====
// dcache answers reads combinationally in the same cycle; addresses are word aligned
`timescale 1ns/1ns
`include "rvPipe_params.svh"
`default_nettype none

module memWbStage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               hold,
    exMemIf.mem                exMem,
    input  logic [`XLEN-1:0]   dcacheRdata,
    output logic               dcacheRen,
    output logic               dcacheWen,
    output logic [`XLEN-3:0]   dcacheAddr,
    output logic [`XLEN-1:0]   dcacheWdata,
    output logic               wbEn,
    output logic [`REG_AW-1:0] wbRd,
    output logic [`XLEN-1:0]   wbData
);

    logic             memToReg;
    logic [`XLEN-1:0] aluOut;
    logic [`XLEN-1:0] loadData;

    // data port straight from the execute/memory register
    assign dcacheRen   = exMem.memRead;
    assign dcacheWen   = exMem.memWrite;
    assign dcacheAddr  = exMem.aluOut[`XLEN-1:2];
    assign dcacheWdata = exMem.storeData;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wbEn     <= 1'b0;
            memToReg <= 1'b0;
        end else if (!hold) begin
            wbEn     <= exMem.regWrite;
            memToReg <= exMem.memToReg;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            wbRd     <= exMem.rd;
            aluOut   <= exMem.aluOut;
            loadData <= dcacheRdata;
        end
    end

    // load word back to little-endian
    assign wbData = memToReg ? {<<8{loadData}} : aluOut;

endmodule

`default_nettype wire

// ==== hdl/regFile.sv ====
// two async read ports, one write port; a same-cycle write is visible on the read ports
`timescale 1ns/1ns
`include "rvPipe_params.svh"
`default_nettype none

module regFile (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wbEn,
    input  logic [`REG_AW-1:0] wbRd,
    input  logic [`XLEN-1:0]   wbData,
    input  logic [`REG_AW-1:0] rs1,
    input  logic [`REG_AW-1:0] rs2,
    output logic [`XLEN-1:0]   rdata1,
    output logic [`XLEN-1:0]   rdata2
);

    logic [`XLEN-1:0] regs [`REG_COUNT];
    logic             wrLive;

    // x0 is never written
    assign wrLive = wbEn && (wbRd != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[wbRd] <= wbData;
        end
    end

    // write-through bypass
    assign rdata1 = (rs1 == '0) ? '0 : (wrLive && wbRd == rs1) ? wbData : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : (wrLive && wbRd == rs2) ? wbData : regs[rs2];

endmodule

`default_nettype wire

// ==== hdl/rvPipePkg.sv ====
// instruction word views for R and S formats; the I and B immediates are rebuilt from these fields
`default_nettype none

package rvPipePkg;

    // one 32-bit instruction, decoded either as R-type or S-type fields
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rView;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } sView;
    } instrWord;

endpackage

`default_nettype wire

// ==== hdl/rvPipeTop.sv ====
// both buses carry big-endian words; stall inputs are levels that freeze the whole core
`timescale 1ns/1ns
`include "rvPipe_params.svh"
`default_nettype none

module rvPipeTop import rvPipePkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    // instruction port
    output logic [`XLEN-3:0]  icacheAddr,
    input  logic [`XLEN-1:0]  icacheRdata,
    input  logic              icacheStall,
    // data port
    output logic              dcacheRen,
    output logic              dcacheWen,
    output logic [`XLEN-3:0]  dcacheAddr,
    output logic [`XLEN-1:0]  dcacheWdata,
    input  logic [`XLEN-1:0]  dcacheRdata,
    input  logic              dcacheStall
);

    instrWord           ifInstr;
    logic [`XLEN-1:0]   ifPc;
    logic               hold;
    logic               loadStall;
    logic [1:0]         fwdA;
    logic [1:0]         fwdB;
    logic               branchTaken;
    logic [`XLEN-1:0]   branchTarget;
    logic               wbEn;
    logic [`REG_AW-1:0] wbRd;
    logic [`XLEN-1:0]   wbData;

    idExIf  idEx ();
    exMemIf exMem ();

    fetchStage fetchStage_inst (
        .clk, .rst_n, .hold, .loadStall, .branchTaken, .branchTarget,
        .icacheRdata, .icacheAddr, .ifInstr, .ifPc
    );

    decodeStage decodeStage_inst (
        .clk, .rst_n, .hold, .loadStall, .branchTaken, .ifInstr, .ifPc,
        .wbEn, .wbRd, .wbData, .idEx(idEx.decode)
    );

    executeStage executeStage_inst (
        .clk, .rst_n, .hold, .fwdA, .fwdB, .wbData,
        .idEx(idEx.execute), .exMem(exMem.execute), .branchTaken, .branchTarget
    );

    memWbStage memWbStage_inst (
        .clk, .rst_n, .hold, .exMem(exMem.mem), .dcacheRdata,
        .dcacheRen, .dcacheWen, .dcacheAddr, .dcacheWdata, .wbEn, .wbRd, .wbData
    );

    hazardUnit hazardUnit_inst (
        .icacheStall, .dcacheStall, .wbEn, .wbRd,
        .idEx(idEx.hazard), .exMem(exMem.hazard), .ifInstr,
        .hold, .loadStall, .fwdA, .fwdB
    );

endmodule

`default_nettype wire

// ==== hdl/rvPipe_params.svh ====
// word width, opcodes and ALU codes cover the RV32I subset only (no jumps, lui or byte access)
`ifndef RVPIPE_PARAMS_SVH
`define RVPIPE_PARAMS_SVH
`default_nettype none

`define XLEN        32
`define REG_COUNT   32
`define REG_AW      5

`define OP_RTYPE    7'b0110011
`define OP_ITYPE    7'b0010011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_BRANCH   7'b1100011

// ALU code is {funct7[5], funct3}
`define ALU_ADD     4'b0000
`define ALU_SUB     4'b1000
`define ALU_SLT     4'b0010
`define ALU_XOR     4'b0100
`define ALU_OR      4'b0110
`define ALU_AND     4'b0111
`define ALU_SLL     4'b0001
`define ALU_SRL     4'b0101
`define ALU_SRA     4'b1101

// ALU-op classes from decode
`define ALUOP_ADD       2'b00
`define ALUOP_BRANCH    2'b01
`define ALUOP_REG       2'b10
`define ALUOP_IMM       2'b11

// addi x0,x0,0
`define INSTR_NOP       32'h0000_0013
// opcode 7'h7f decodes to all-zero control
`define INSTR_BUBBLE    32'h0000_007f
`define PC_STEP         32'd4

`default_nettype wire
`endif

// ==== hdl/stageIf.sv ====
// stage registers only; decode and execute are the sole writers of these interfaces
`timescale 1ns/1ns
`include "rvPipe_params.svh"
`default_nettype none

// ============================================================
// decode/execute register
// ============================================================
interface idExIf;
    logic               regWrite;
    logic               memToReg;
    logic               memRead;
    logic               memWrite;
    logic               branch;
    logic               aluSrc;
    logic [1:0]         aluOp;
    logic [`REG_AW-1:0] rs1;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rd;
    logic [2:0]         funct3;
    logic               funct7b5;
    logic [`XLEN-1:0]   imm;
    logic [`XLEN-1:0]   pc;
    logic [`XLEN-1:0]   rdata1;
    logic [`XLEN-1:0]   rdata2;

    modport decode (output regWrite, memToReg, memRead, memWrite, branch, aluSrc, aluOp,
                    rs1, rs2, rd, funct3, funct7b5, imm, pc, rdata1, rdata2);
    modport execute (input regWrite, memToReg, memRead, memWrite, branch, aluSrc, aluOp,
                     rs1, rs2, rd, funct3, funct7b5, imm, pc, rdata1, rdata2);
    modport hazard (input memRead, rd, rs1, rs2);
endinterface

// ============================================================
// execute/memory register
// ============================================================
interface exMemIf;
    logic               regWrite;
    logic               memToReg;
    logic               memRead;
    logic               memWrite;
    logic [`XLEN-1:0]   aluOut;
    logic [`XLEN-1:0]   storeData;
    logic [`REG_AW-1:0] rd;

    modport execute (output regWrite, memToReg, memRead, memWrite, aluOut, storeData, rd);
    modport mem (input regWrite, memToReg, memRead, memWrite, aluOut, storeData, rd);
    modport hazard (input regWrite, rd);
endinterface

`default_nettype wire

// ==== project.f ====
+incdir+hdl
hdl/rvPipePkg.sv
hdl/stageIf.sv
hdl/fetchStage.sv
hdl/regFile.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memWbStage.sv
hdl/hazardUnit.sv
hdl/rvPipeTop.sv
testbench/rvPipe_props.sv
testbench/rvPipeTb.sv

// ==== run.sh ====
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module rvPipeTb -f project.f -o simv > sim.log 2>&1 \
    && ./obj_dir/simv >> sim.log 2>&1 \
    || echo "Finished with errors" >> sim.log
grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// ==== testbench/rvPipeTb.sv ====
// memories are 64 words each; stores are checked in program order, loads rely on the bus byte order
`timescale 1ns/1ns
`include "rvPipe_params.svh"
`default_nettype none

module rvPipeTb;

    logic        clk;
    logic        rst_n;
    logic [29:0] icacheAddr;
    logic [31:0] icacheRdata;
    logic        icacheStall;
    logic        dcacheRen;
    logic        dcacheWen;
    logic [29:0] dcacheAddr;
    logic [31:0] dcacheWdata;
    logic [31:0] dcacheRdata;
    logic        dcacheStall;

    // bus-order memories
    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    // reference model state, native order
    logic [31:0] modelRegs [32];
    logic [31:0] modelMem [64];
    logic [31:0] prog [$];
    string       progTag [$];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    string       expTest [$];
    int          progLen = 0;
    int          storeIdx = 0;
    integer      seed = 98;

    rvPipeTop rvPipeTop_inst (
        .clk, .rst_n, .icacheAddr, .icacheRdata, .icacheStall,
        .dcacheRen, .dcacheWen, .dcacheAddr, .dcacheWdata, .dcacheRdata, .dcacheStall
    );

    assign icacheRdata = imem[icacheAddr[5:0]];
    // read data only while the read enable is up
    assign dcacheRdata = dcacheRen ? dmem[dcacheAddr[5:0]] : '0;

    // ============================================================
    // helpers
    // ============================================================
    function automatic logic [31:0] byteSwap(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic logic [31:0] fillWord(input int i);
        logic [31:0] a;
        a = i;
        return {a[15:0] ^ 16'hc3a5, ~a[15:0]};
    endfunction

    function automatic logic [31:0] encR(input int f7, input int rs2, input int rs1,
                                         input int f3, input int rd);
        logic [31:0] a7;
        logic [31:0] a2;
        logic [31:0] a1;
        logic [31:0] a3;
        logic [31:0] ad;
        a7 = f7;
        a2 = rs2;
        a1 = rs1;
        a3 = f3;
        ad = rd;
        return {a7[6:0], a2[4:0], a1[4:0], a3[2:0], ad[4:0], `OP_RTYPE};
    endfunction

    // I-type and load share one layout
    function automatic logic [31:0] encI(input logic [6:0] op, input int imm, input int rs1,
                                         input int f3, input int rd);
        logic [31:0] ai;
        logic [31:0] a1;
        logic [31:0] a3;
        logic [31:0] ad;
        ai = imm;
        a1 = rs1;
        a3 = f3;
        ad = rd;
        return {ai[11:0], a1[4:0], a3[2:0], ad[4:0], op};
    endfunction

    function automatic logic [31:0] encS(input int imm, input int rs2, input int rs1);
        logic [31:0] ai;
        logic [31:0] a2;
        logic [31:0] a1;
        ai = imm;
        a2 = rs2;
        a1 = rs1;
        return {ai[11:5], a2[4:0], a1[4:0], 3'b010, ai[4:0], `OP_STORE};
    endfunction

    function automatic logic [31:0] encB(input int imm, input int rs2, input int rs1,
                                         input int f3);
        logic [31:0] ai;
        logic [31:0] a2;
        logic [31:0] a1;
        logic [31:0] a3;
        ai = imm;
        a2 = rs2;
        a1 = rs1;
        a3 = f3;
        return {ai[12], ai[10:5], a2[4:0], a1[4:0], a3[2:0], ai[4:1], ai[11], `OP_BRANCH};
    endfunction

    // tag every untagged instruction with the section name
    task automatic labelSection(input string name);
        while (progTag.size() < prog.size()) begin
            progTag.push_back(name);
        end
    endtask

    // ============================================================
    // ISA reference, returns the next pc
    // ============================================================
    function automatic logic [31:0] isaStep(input logic [31:0] instr, input logic [31:0] pc);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] res;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        alt;
        rd   = instr[11:7];
        f3   = instr[14:12];
        alt  = instr[30];
        a    = modelRegs[instr[19:15]];
        b    = modelRegs[instr[24:20]];
        immI = {{20{instr[31]}}, instr[31:20]};
        immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        res  = '0;
        if (instr[6:0] == `OP_ITYPE) begin
            b   = immI;
            // only srai carries the alternate bit
            alt = alt && (f3 == 3'b101);
        end
        case (instr[6:0])
            `OP_RTYPE, `OP_ITYPE: begin
                case (f3)
                    3'b000: res = alt ? a - b : a + b;
                    3'b001: res = a << b[4:0];
                    3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b100: res = a ^ b;
                    3'b101: begin
                        res = a >> b[4:0];
                        // arithmetic shift refills the vacated top bits with the sign
                        if (alt && a[31]) res = res | ~(32'hffff_ffff >> b[4:0]);
                    end
                    3'b110: res = a | b;
                    default: res = a & b;
                endcase
                if (rd != 0) modelRegs[rd] = res;
            end
            `OP_LOAD: begin
                res = a + immI;
                if (rd != 0) modelRegs[rd] = modelMem[res[7:2]];
            end
            `OP_STORE: begin
                res = a + immS;
                modelMem[res[7:2]] = b;
                expAddr.push_back(res);
                expData.push_back(b);
                expTest.push_back(progTag[pc[31:2]]);
            end
            `OP_BRANCH: begin
                if ((f3 == 3'b000) ? (a == b) : (a != b)) return pc + immB;
            end
            default: ;
        endcase
        return pc + 32'd4;
    endfunction

    task automatic reportFail(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    // ============================================================
    // program, reference run, clock and reset
    // ============================================================
    initial begin
        logic [31:0] pc;
        logic [31:0] nextPc;
        icacheStall = 1'b0;
        dcacheStall = 1'b0;
        rst_n       = 1'b1;
        // operands
        prog.push_back(encI(`OP_ITYPE, -100, 0, 0, 1));
        prog.push_back(encI(`OP_ITYPE, 7, 0, 0, 2));
        // distance 1 and 2 producers
        prog.push_back(encR(0, 2, 1, 0, 3));
        prog.push_back(encR(32, 1, 3, 0, 4));
        prog.push_back(encS(0, 3, 0));
        prog.push_back(encS(4, 4, 0));
        labelSection("forwarding");
        // R-type set, slt both signs, sra negative
        prog.push_back(encR(0, 2, 1, 2, 5));
        prog.push_back(encR(0, 1, 2, 2, 6));
        prog.push_back(encR(0, 2, 1, 4, 7));
        prog.push_back(encR(0, 2, 1, 6, 8));
        prog.push_back(encR(0, 2, 1, 7, 9));
        prog.push_back(encR(0, 2, 2, 1, 10));
        prog.push_back(encR(0, 2, 1, 5, 11));
        prog.push_back(encR(32, 2, 1, 5, 12));
        for (int r = 5; r <= 12; r++) prog.push_back(encS(8 + 4 * (r - 5), r, 0));
        labelSection("alu reg");
        // I-type set
        prog.push_back(encI(`OP_ITYPE, -5, 1, 2, 13));
        prog.push_back(encI(`OP_ITYPE, 'h55, 1, 4, 14));
        prog.push_back(encI(`OP_ITYPE, -16, 2, 6, 15));
        prog.push_back(encI(`OP_ITYPE, 'hff, 1, 7, 16));
        prog.push_back(encI(`OP_ITYPE, 28, 2, 1, 17));
        prog.push_back(encI(`OP_ITYPE, 4, 1, 5, 18));
        prog.push_back(encI(`OP_ITYPE, 'h404, 1, 5, 19));
        for (int r = 13; r <= 19; r++) prog.push_back(encS(40 + 4 * (r - 13), r, 0));
        labelSection("alu imm");
        // load-use, untouched word, store then load back
        prog.push_back(encI(`OP_LOAD, 4, 0, 2, 20));
        prog.push_back(encR(0, 20, 20, 0, 21));
        prog.push_back(encS(68, 21, 0));
        prog.push_back(encI(`OP_LOAD, 200, 0, 2, 22));
        prog.push_back(encS(72, 22, 0));
        prog.push_back(encS(76, 1, 0));
        prog.push_back(encI(`OP_LOAD, 76, 0, 2, 23));
        prog.push_back(encS(80, 23, 0));
        labelSection("load store");
        // x0 writes are dropped
        prog.push_back(encI(`OP_ITYPE, 55, 0, 0, 0));
        prog.push_back(encR(0, 2, 1, 0, 0));
        prog.push_back(encS(84, 0, 0));
        labelSection("x0");
        // branches, each taken one skips two stores
        prog.push_back(encB(8, 2, 1, 0));
        prog.push_back(encS(88, 2, 0));
        prog.push_back(encB(12, 2, 1, 1));
        prog.push_back(encS(92, 1, 0));
        prog.push_back(encS(96, 1, 0));
        prog.push_back(encB(12, 2, 2, 0));
        prog.push_back(encS(92, 2, 0));
        prog.push_back(encS(96, 2, 0));
        prog.push_back(encB(8, 2, 2, 1));
        prog.push_back(encS(100, 7, 0));
        prog.push_back(encB(0, 0, 0, 0));
        labelSection("branch");
        for (int i = 0; i < 64; i++) begin
            imem[i]      = (i < prog.size()) ? byteSwap(prog[i]) : byteSwap(`INSTR_NOP);
            dmem[i]      = byteSwap(fillWord(i));
            modelMem[i]  = fillWord(i);
        end
        for (int i = 0; i < 32; i++) modelRegs[i] = '0;
        pc = '0;
        for (int s = 0; s < 1000; s++) begin
            nextPc = isaStep(prog[pc[31:2]], pc);
            if (nextPc == pc) break;
            pc = nextPc;
        end
        progLen = prog.size();
        #5 rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // random back-pressure, about one cycle in four per port
    always @(posedge clk) begin
        icacheStall <= (($random(seed) & 3) == 0);
        dcacheStall <= (($random(seed) & 3) == 0);
    end

    // ============================================================
    // store compare and data memory write
    // ============================================================
    always @(posedge clk) begin
        if (rst_n && dcacheWen && !dcacheStall && !icacheStall) begin
            dmem[dcacheAddr[5:0]] <= dcacheWdata;
            assert (dcacheAddr == expAddr[storeIdx][31:2])
                else reportFail($sformatf(
                    "mismatch %s store %0d address expected %h actual %h",
                    expTest[storeIdx], storeIdx, expAddr[storeIdx][31:2], dcacheAddr));
            assert (dcacheWdata == byteSwap(expData[storeIdx]))
                else reportFail($sformatf(
                    "mismatch %s store %0d data expected %h actual %h",
                    expTest[storeIdx], storeIdx, byteSwap(expData[storeIdx]), dcacheWdata));
            storeIdx = storeIdx + 1;
            if (storeIdx == expData.size()) begin
                $display("Finished with no errors");
                $finish;
            end
        end
    end

    // watchdog sized from the program length
    initial begin
        wait (progLen != 0);
        #(progLen * 8 * 40);
        reportFail($sformatf("timeout after %0d of %0d stores", storeIdx, expData.size()));
    end

endmodule

`default_nettype wire

// ==== testbench/rvPipe_props.sv ====
// checks only the data port and the freeze; sampled on clk, quiet while rst_n is low
`timescale 1ns/1ns
`include "rvPipe_params.svh"
`default_nettype none

module rvPipeProps (
    input wire logic             clk,
    input wire logic             rst_n,
    input wire logic             icacheStall,
    input wire logic             dcacheStall,
    input wire logic             dcacheRen,
    input wire logic             dcacheWen,
    input wire logic [`XLEN-3:0] dcacheAddr,
    input wire logic [`XLEN-1:0] dcacheWdata
);

    // one access kind per cycle
    enableExclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(dcacheRen && dcacheWen)) else $error("read and write enables high together");

    // frozen pipe keeps the data port steady
    holdStable: assert property (@(posedge clk) disable iff (!rst_n)
        (icacheStall || dcacheStall) |=>
            $stable({dcacheRen, dcacheWen, dcacheAddr, dcacheWdata}))
        else $error("data port changed during a stall");

    resetQuiet: assert property (@(posedge clk) $rose(rst_n) |-> !dcacheRen && !dcacheWen)
        else $error("data port enabled right after reset");

endmodule

bind rvPipeTop rvPipeProps rvPipeProps_inst (
    .clk, .rst_n, .icacheStall, .dcacheStall, .dcacheRen, .dcacheWen, .dcacheAddr, .dcacheWdata
);

`default_nettype wire
